// ==== core_pkg.sv ====
`default_nettype none

package core_pkg;

  ////////////////////
  // machine sizes
  ////////////////////
  localparam int ARCH_REGS = 8;                    // architectural registers
  localparam int PHYS_REGS = 16;                   // physical registers
  localparam int ROB_DEPTH = 8;                    // reorder buffer slots
  localparam int FL_DEPTH  = PHYS_REGS - ARCH_REGS; // tags not mapped at reset

  localparam int ARCH_W    = $clog2(ARCH_REGS);
  localparam int TAG_W     = $clog2(PHYS_REGS);
  localparam int ROB_IDX_W = $clog2(ROB_DEPTH);
  localparam int FL_IDX_W  = $clog2(FL_DEPTH);
  localparam int DATA_W    = 32;

  ////////////////////
  // typed vectors
  ////////////////////
  typedef logic [ARCH_W-1:0]    arch_idx_t;
  typedef logic [TAG_W-1:0]     phys_tag_t;
  typedef logic [ROB_IDX_W-1:0] rob_idx_t;
  typedef logic [ROB_IDX_W:0]   rob_ptr_t;  // extra msb is the wrap bit
  typedef logic [FL_IDX_W:0]    fl_ptr_t;   // same trick for the free list
  typedef logic [DATA_W-1:0]    data_t;

  // arch reg r sits in phys tag r out of reset
  function automatic phys_tag_t reset_map_tag(input arch_idx_t r);
    return phys_tag_t'(r);
  endfunction

  // free list slot i holds tag ARCH_REGS+i, lowest tag at the head
  function automatic phys_tag_t reset_free_tag(input int i);
    return phys_tag_t'(ARCH_REGS + i);
  endfunction

endpackage

`default_nettype wire

// ==== free_list.sv ====
`timescale 1ns/10ps
`default_nettype none

module free_list import core_pkg::*; (
  input  wire logic      clock,
  input  wire logic      reset,
  input  wire logic      dispatch_fire,  // pop head_tag
  input  wire logic      retire_fire,    // push retire_told
  input  wire phys_tag_t retire_told,
  output logic           tag_avail,      // queue not empty
  output phys_tag_t      head_tag
);

  ////////////////////
  // queue storage
  ////////////////////
  phys_tag_t fl_mem [FL_DEPTH];
  fl_ptr_t   head_ptr;
  fl_ptr_t   tail_ptr;

  // empty when both pointers match including the wrap bit
  assign tag_avail = (head_ptr != tail_ptr);
  assign head_tag  = fl_mem[head_ptr[FL_IDX_W-1:0]];

  ////////////////////
  // pointer update
  ////////////////////
  always_ff @(posedge clock) begin
    if (reset) begin
      head_ptr <= '0;
      tail_ptr <= fl_ptr_t'(FL_DEPTH); // starts full
    end else begin
      if (dispatch_fire) begin
        head_ptr <= head_ptr + fl_ptr_t'(1);
      end
      if (retire_fire) begin
        tail_ptr <= tail_ptr + fl_ptr_t'(1);
      end
    end
  end

  // slot contents
  // reset loads the initial free tags, later only pushes write here
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < FL_DEPTH; i++) begin
        fl_mem[i] <= reset_free_tag(i);
      end
    end else if (retire_fire) begin
      // tail never overruns head, only FL_DEPTH tags can be free at once
      fl_mem[tail_ptr[FL_IDX_W-1:0]] <= retire_told;
    end
  end

  // pop and push may share a cycle
  // told tag becomes visible at head only after its edge

endmodule

`default_nettype wire

// ==== map_table.sv ====
`timescale 1ns/10ps
`default_nettype none

module map_table import core_pkg::*; (
  input  wire logic      clock,
  input  wire logic      reset,
  input  wire logic      dispatch_fire,
  input  wire arch_idx_t dispatch_dest,
  input  wire phys_tag_t new_tag,        // fresh tag from the free list head
  output phys_tag_t      told
);

  ////////////////////
  // speculative map
  ////////////////////
  phys_tag_t map_mem [ARCH_REGS];  // one tag per arch reg

  // old mapping of the dest goes out as told
  assign told = map_mem[dispatch_dest];

  always_ff @(posedge clock) begin
    if (reset) begin
      // identity mapping out of reset
      for (int r = 0; r < ARCH_REGS; r++) begin
        map_mem[r] <= reset_map_tag(arch_idx_t'(r));
      end
    end else if (dispatch_fire) begin
      map_mem[dispatch_dest] <= new_tag;  // rename
    end
  end

  // no rollback path here
  // retire keeps its own committed copy

endmodule

`default_nettype wire

// ==== reorder_buffer.sv ====
`timescale 1ns/10ps
`default_nettype none

module reorder_buffer import core_pkg::*; (
  input  wire logic      clock,
  input  wire logic      reset,
  input  wire logic      dispatch_valid,
  input  wire logic      tag_avail,        // free list not empty
  input  wire arch_idx_t dispatch_dest,
  input  wire phys_tag_t new_tag,
  input  wire phys_tag_t told,             // from map_table
  input  wire logic      complete_valid,
  input  wire rob_idx_t  complete_rob_idx,
  input  wire logic      retire_fire,      // pop head
  output logic           dispatch_ready,
  output logic           dispatch_fire,
  output rob_idx_t       dispatch_rob_idx,
  output logic           head_done,        // head occupied and finished
  output arch_idx_t      head_dest,
  output phys_tag_t      head_tag,
  output phys_tag_t      head_told
);

  ////////////////////
  // entry storage
  ////////////////////
  arch_idx_t dest_mem [ROB_DEPTH];
  phys_tag_t tag_mem  [ROB_DEPTH];
  phys_tag_t told_mem [ROB_DEPTH];
  logic [ROB_DEPTH-1:0] done_bits;

  rob_ptr_t head_ptr;
  rob_ptr_t tail_ptr;
  rob_idx_t head_idx;
  rob_idx_t tail_idx;
  logic     rob_empty;
  logic     rob_full;

  assign head_idx = head_ptr[ROB_IDX_W-1:0];
  assign tail_idx = tail_ptr[ROB_IDX_W-1:0];

  // full when only the wrap bits differ
  assign rob_empty = (head_ptr == tail_ptr);
  assign rob_full  = (head_ptr[ROB_IDX_W] != tail_ptr[ROB_IDX_W]) &&
                     (head_idx == tail_idx);

  ////////////////////
  // dispatch accept
  ////////////////////
  // the only place acceptance is decided
  assign dispatch_ready   = tag_avail && !rob_full;
  assign dispatch_fire    = dispatch_valid && dispatch_ready;
  assign dispatch_rob_idx = tail_idx;  // slot handed out this cycle

  // head view for retire
  assign head_done = !rob_empty && done_bits[head_idx];
  assign head_dest = dest_mem[head_idx];
  assign head_tag  = tag_mem[head_idx];
  assign head_told = told_mem[head_idx];

  // pointers
  always_ff @(posedge clock) begin
    if (reset) begin
      head_ptr <= '0;
      tail_ptr <= '0;
    end else begin
      if (dispatch_fire) tail_ptr <= tail_ptr + rob_ptr_t'(1);
      if (retire_fire)   head_ptr <= head_ptr + rob_ptr_t'(1);
    end
  end

  // done bits
  always_ff @(posedge clock) begin
    if (reset) begin
      done_bits <= '0;
    end else begin
      if (complete_valid) done_bits[complete_rob_idx] <= 1'b1;
      if (dispatch_fire)  done_bits[tail_idx] <= 1'b0;  // fresh entry not done
    end
  end

  // payload written at tail
  always_ff @(posedge clock) begin
    if (dispatch_fire) begin
      dest_mem[tail_idx] <= dispatch_dest;
      tag_mem[tail_idx]  <= new_tag;
      told_mem[tail_idx] <= told;
    end
  end

endmodule

`default_nettype wire

// ==== phys_regfile.sv ====
`timescale 1ns/10ps
`default_nettype none

module phys_regfile import core_pkg::*; (
  input  wire logic      clock,
  input  wire logic      reset,
  input  wire logic      complete_valid,
  input  wire phys_tag_t complete_tag,
  input  wire data_t     complete_value,
  input  wire phys_tag_t read_tag,      // retire read port
  output data_t          read_value
);

  ////////////////////
  // value array
  ////////////////////
  data_t rf_mem [PHYS_REGS];

  // plain read, no bypass from the write port
  // retire reads only entries written on an earlier edge
  assign read_value = rf_mem[read_tag];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int t = 0; t < PHYS_REGS; t++) begin
        rf_mem[t] <= '0;
      end
    end else if (complete_valid) begin
      rf_mem[complete_tag] <= complete_value;  // result lands here
    end
  end

  // one write and one read per cycle
  // completion port has no back-pressure so write always succeeds

endmodule

`default_nettype wire

// ==== retire_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module retire_stage import core_pkg::*; (
  input  wire logic      clock,
  input  wire logic      reset,
  input  wire logic      head_done,
  input  wire arch_idx_t head_dest,
  input  wire phys_tag_t head_tag,
  input  wire phys_tag_t head_told,
  input  wire data_t     rf_read_value,
  output logic           retire_fire,
  output phys_tag_t      rf_read_tag,
  output phys_tag_t      retire_told,   // back to the free list
  output logic           commit_valid,
  output arch_idx_t      commit_dest,
  output phys_tag_t      commit_tag,
  output data_t          commit_value
);

  ////////////////////
  // retire decision
  ////////////////////
  assign retire_fire = head_done;   // one per cycle, head only
  assign rf_read_tag = head_tag;    // fetch the committed value
  assign retire_told = head_told;

  // committed arch map, kept for recovery
  phys_tag_t arch_map [ARCH_REGS];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int r = 0; r < ARCH_REGS; r++) begin
        arch_map[r] <= reset_map_tag(arch_idx_t'(r));
      end
    end else if (retire_fire) begin
      arch_map[head_dest] <= head_tag;
    end
  end

  ////////////////////
  // commit outputs
  ////////////////////
  always_ff @(posedge clock) begin
    if (reset) commit_valid <= 1'b0;
    else       commit_valid <= retire_fire;  // one cycle pulse per commit
  end

  always_ff @(posedge clock) begin
    if (retire_fire) begin
      commit_dest  <= head_dest;
      commit_tag   <= head_tag;
      commit_value <= rf_read_value;
    end
  end

endmodule

`default_nettype wire

// ==== rename_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module rename_core import core_pkg::*; (
  input  wire logic      clock,
  input  wire logic      reset,
  // dispatch port
  input  wire logic      dispatch_valid,
  input  wire arch_idx_t dispatch_dest,
  output logic           dispatch_ready,
  output phys_tag_t      dispatch_tag,
  output phys_tag_t      dispatch_told,
  output rob_idx_t       dispatch_rob_idx,
  // completion port
  input  wire logic      complete_valid,
  input  wire phys_tag_t complete_tag,
  input  wire rob_idx_t  complete_rob_idx,
  input  wire data_t     complete_value,
  // commit port
  output logic           commit_valid,
  output arch_idx_t      commit_dest,
  output phys_tag_t      commit_tag,
  output data_t          commit_value
);

  ////////////////////
  // internal wires
  ////////////////////
  logic      tag_avail;
  logic      dispatch_fire;   // decided in the rob
  logic      head_done;
  arch_idx_t head_dest;
  phys_tag_t head_tag;
  phys_tag_t head_told;
  logic      retire_fire;
  phys_tag_t retire_told;
  phys_tag_t rf_read_tag;
  data_t     rf_read_value;

  // producer side
  free_list free_list_0 (
    .clock         (clock),
    .reset         (reset),
    .dispatch_fire (dispatch_fire),
    .retire_fire   (retire_fire),
    .retire_told   (retire_told),
    .tag_avail     (tag_avail),
    .head_tag      (dispatch_tag)    // fresh tag straight out
  );

  map_table map_table_0 (
    .clock         (clock),
    .reset         (reset),
    .dispatch_fire (dispatch_fire),
    .dispatch_dest (dispatch_dest),
    .new_tag       (dispatch_tag),
    .told          (dispatch_told)
  );

  // buffer
  reorder_buffer reorder_buffer_0 (
    .clock            (clock),
    .reset            (reset),
    .dispatch_valid   (dispatch_valid),
    .tag_avail        (tag_avail),
    .dispatch_dest    (dispatch_dest),
    .new_tag          (dispatch_tag),
    .told             (dispatch_told),
    .complete_valid   (complete_valid),
    .complete_rob_idx (complete_rob_idx),
    .retire_fire      (retire_fire),
    .dispatch_ready   (dispatch_ready),
    .dispatch_fire    (dispatch_fire),
    .dispatch_rob_idx (dispatch_rob_idx),
    .head_done        (head_done),
    .head_dest        (head_dest),
    .head_tag         (head_tag),
    .head_told        (head_told)
  );

  phys_regfile phys_regfile_0 (
    .clock          (clock),
    .reset          (reset),
    .complete_valid (complete_valid),
    .complete_tag   (complete_tag),
    .complete_value (complete_value),
    .read_tag       (rf_read_tag),
    .read_value     (rf_read_value)
  );

  // consumer side
  retire_stage retire_stage_0 (
    .clock         (clock),
    .reset         (reset),
    .head_done     (head_done),
    .head_dest     (head_dest),
    .head_tag      (head_tag),
    .head_told     (head_told),
    .rf_read_value (rf_read_value),
    .retire_fire   (retire_fire),
    .rf_read_tag   (rf_read_tag),
    .retire_told   (retire_told),
    .commit_valid  (commit_valid),
    .commit_dest   (commit_dest),
    .commit_tag    (commit_tag),
    .commit_value  (commit_value)
  );

endmodule

`default_nettype wire

// ==== rename_core_properties.sv ====
`timescale 1ns/10ps
`default_nettype none

module rename_core_properties import core_pkg::*; (
  input wire logic      clock,
  input wire logic      reset,
  input wire logic      dispatch_ready,
  input wire logic      dispatch_fire,
  input wire rob_idx_t  dispatch_rob_idx,
  input wire phys_tag_t dispatch_tag,
  input wire logic      commit_valid,
  input wire phys_tag_t commit_tag
);

  ////////////////////
  // slot bookkeeping
  ////////////////////
  phys_tag_t slot_tag [ROB_DEPTH];  // tag given out per slot
  rob_idx_t  commit_slot;           // slot the next commit comes from
  int        fail_count = 0;

  always_ff @(posedge clock) begin
    if (dispatch_fire) slot_tag[dispatch_rob_idx] <= dispatch_tag;
  end

  always_ff @(posedge clock) begin
    if (reset) commit_slot <= '0;
    else if (commit_valid) commit_slot <= commit_slot + rob_idx_t'(1);
  end

  a_commit_known: assert property (@(posedge clock) disable iff (reset)
    !$isunknown(commit_valid))
    else begin
      $error("commit_valid is unknown after reset");
      fail_count++;
    end

  // a refused dispatch leaves the tail slot where it was
  a_no_fire_unready: assert property (@(posedge clock) disable iff (reset)
    !dispatch_ready |=> $stable(dispatch_rob_idx))
    else begin
      $error("dispatch accepted while dispatch_ready low");
      fail_count++;
    end

  // commits walk the slots one by one
  a_commit_slot_order: assert property (@(posedge clock) disable iff (reset)
    commit_valid |-> (commit_tag == slot_tag[commit_slot]))
    else begin
      $error("commit does not come from the next reorder buffer slot");
      fail_count++;
    end

endmodule

bind rename_core rename_core_properties rename_core_props (
  .clock            (clock),
  .reset            (reset),
  .dispatch_ready   (dispatch_ready),
  .dispatch_fire    (dispatch_fire),
  .dispatch_rob_idx (dispatch_rob_idx),
  .dispatch_tag     (dispatch_tag),
  .commit_valid     (commit_valid),
  .commit_tag       (commit_tag)
);

`default_nettype wire

// ==== rename_core_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module rename_core_tb import core_pkg::*; ();

  logic      clock;
  logic      reset;
  logic      dispatch_valid;
  arch_idx_t dispatch_dest;
  logic      complete_valid;
  phys_tag_t complete_tag;
  rob_idx_t  complete_rob_idx;
  data_t     complete_value;
  logic      dispatch_ready;
  phys_tag_t dispatch_tag;
  phys_tag_t dispatch_told;
  rob_idx_t  dispatch_rob_idx;
  logic      commit_valid;
  arch_idx_t commit_dest;
  phys_tag_t commit_tag;
  data_t     commit_value;

  rename_core UUT (.*);

  initial clock = 1'b0;
  always #4 clock = ~clock;  // 8 ns period

  ////////////////////
  // reference model
  ////////////////////
  phys_tag_t m_free [$];         // free tags, head first
  phys_tag_t m_map  [ARCH_REGS]; // speculative map
  phys_tag_t m_commit [ARCH_REGS]; // committed map
  data_t     m_val  [PHYS_REGS]; // value per tag
  arch_idx_t q_dest [$];         // in-flight entries, oldest first
  phys_tag_t q_tag  [$];
  phys_tag_t q_told [$];
  rob_idx_t  q_idx  [$];
  bit        q_done [$];
  rob_idx_t  m_tail;
  logic      m_fired;
  logic      x_cv;               // commit expected this cycle
  arch_idx_t x_cd;
  phys_tag_t x_ct;
  data_t     x_cval;

  int    errors;
  int    start_errors;
  int    tests_passed;
  int    tests_failed;
  int    n_dispatched;           // accepts seen on the port
  int    n_committed;            // commit pulses seen on the port
  string cur_test;

  task automatic check_value(input string what, input logic [31:0] expv,
                             input logic [31:0] actv);
    if (actv !== expv) begin
      $display("CHECK FAILED %s %s: expected %h, actual %h", cur_test, what, expv, actv);
      errors++;
    end
  endtask

  task automatic model_reset();
    m_free.delete();
    q_dest.delete();
    q_tag.delete();
    q_told.delete();
    q_idx.delete();
    q_done.delete();
    for (int i = 0; i < FL_DEPTH; i++) m_free.push_back(phys_tag_t'(ARCH_REGS + i));
    for (int r = 0; r < ARCH_REGS; r++) m_map[r] = phys_tag_t'(r);  // identity
    for (int r = 0; r < ARCH_REGS; r++) m_commit[r] = phys_tag_t'(r);
    for (int t = 0; t < PHYS_REGS; t++) m_val[t] = '0;
    m_tail = '0;
    x_cv   = 1'b0;
  endtask

  task automatic apply_reset();
    @(posedge clock);
    reset          <= 1'b1;
    dispatch_valid <= 1'b0;
    complete_valid <= 1'b0;
    repeat (4) @(posedge clock);
    reset <= 1'b0;
    model_reset();
  endtask

  // one clock: drive at rise, compare at fall, then step the model
  task automatic cycle(input logic dv, input arch_idx_t dd, input logic cv,
                       input phys_tag_t ct, input rob_idx_t ci, input data_t cval);
    logic      m_ready;
    logic      retire;
    phys_tag_t r_told;
    phys_tag_t new_tag;
    @(posedge clock);
    dispatch_valid   <= dv;
    dispatch_dest    <= dd;
    complete_valid   <= cv;
    complete_tag     <= ct;
    complete_rob_idx <= ci;
    complete_value   <= cval;
    @(negedge clock);
    m_ready = (m_free.size() > 0) && (q_tag.size() < ROB_DEPTH);
    m_fired = dv && m_ready;
    if (dv && dispatch_ready === 1'b1) n_dispatched++;
    if (commit_valid === 1'b1) n_committed++;
    check_value("dispatch_ready", m_ready, dispatch_ready);
    if (m_fired) begin
      check_value("dispatch_tag", m_free[0], dispatch_tag);
      check_value("dispatch_told", m_map[dd], dispatch_told);
      check_value("dispatch_rob_idx", m_tail, dispatch_rob_idx);
    end
    check_value("commit_valid", x_cv, commit_valid);
    if (x_cv) begin
      check_value("commit_dest", x_cd, commit_dest);
      check_value("commit_tag", x_ct, commit_tag);
      check_value("commit_value", x_cval, commit_value);
    end
    // state change at the coming edge
    retire = (q_done.size() > 0) && q_done[0];  // head done
    x_cv   = retire;
    if (retire) begin
      x_cd   = q_dest.pop_front();
      x_ct   = q_tag.pop_front();
      x_cval = m_val[x_ct];
      r_told = q_told.pop_front();
      void'(q_idx.pop_front());
      void'(q_done.pop_front());
      m_commit[x_cd] = x_ct;
    end
    if (m_fired) begin
      new_tag = m_free.pop_front();
      q_dest.push_back(dd);
      q_tag.push_back(new_tag);
      q_told.push_back(m_map[dd]);
      q_idx.push_back(m_tail);
      q_done.push_back(1'b0);
      m_map[dd] = new_tag;
      m_tail++;
    end
    if (retire) m_free.push_back(r_told);  // after the pop
    if (cv) begin
      m_val[ct] = cval;
      foreach (q_idx[k]) if (q_idx[k] == ci) q_done[k] = 1'b1;
    end
  endtask

  task automatic idle();
    cycle(1'b0, '0, 1'b0, '0, '0, '0);
  endtask

  task automatic dispatch(input arch_idx_t dest);
    cycle(1'b1, dest, 1'b0, '0, '0, '0);
  endtask

  task automatic complete_pos(input int k, input data_t val);
    cycle(1'b0, '0, 1'b1, q_tag[k], q_idx[k], val);
  endtask

  // position of a random unfinished entry, -1 if none
  function automatic int pick_undone(input bit first);
    int cand [$];
    foreach (q_done[k]) if (!q_done[k]) cand.push_back(k);
    if (cand.size() == 0) return -1;
    if (first) return cand[0];
    return cand[$urandom % cand.size()];
  endfunction

  task automatic wait_commit();
    int n;
    n = 0;
    while (commit_valid !== 1'b1 && n < 20) begin
      idle();
      n++;
    end
    if (commit_valid !== 1'b1) begin
      $display("TIMEOUT in %s: no commit seen within 20 cycles", cur_test);
      errors++;
    end
  endtask

  // finish every outstanding entry in slot order
  task automatic drain();
    int n;
    int k;
    n = 0;
    while ((q_tag.size() > 0 || x_cv) && n < 64) begin
      k = pick_undone(1'b1);
      if (k >= 0) complete_pos(k, data_t'($urandom));
      else idle();
      n++;
    end
    if (q_tag.size() > 0 || x_cv) begin
      $display("TIMEOUT in %s: entries still in flight after 64 cycles", cur_test);
      errors++;
    end
    // retire keeps its own committed copy
    for (int r = 0; r < ARCH_REGS; r++) begin
      check_value("committed map", m_commit[r], UUT.retire_stage_0.arch_map[r]);
    end
  endtask

  task automatic begin_test(input string name);
    cur_test     = name;
    start_errors = errors;
    n_dispatched = 0;
    n_committed  = 0;
    apply_reset();
  endtask

  task automatic end_test();
    if (errors == start_errors) tests_passed++;
    else tests_failed++;
    $display("test %s finished with %0d errors", cur_test, errors - start_errors);
  endtask

  ////////////////////
  // directed tests
  ////////////////////
  task automatic test_reset_state();
    begin_test("reset_state");
    idle();
    check_value("ready after reset", 1, dispatch_ready);
    check_value("commit_valid after reset", 0, commit_valid);
    dispatch(3'd5);
    check_value("first tag", ARCH_REGS, dispatch_tag);
    check_value("first told", 5, dispatch_told);
    check_value("first slot", 0, dispatch_rob_idx);
    drain();
    end_test();
  endtask

  task automatic test_told_chain();
    begin_test("told_chain");
    for (int i = 0; i < 3; i++) begin
      dispatch(3'd2);
      check_value("chain tag", ARCH_REGS + i, dispatch_tag);
      check_value("chain told", (i == 0) ? 2 : ARCH_REGS + i - 1, dispatch_told);
    end
    dispatch(3'd6);  // untouched reg keeps identity
    check_value("other told", 6, dispatch_told);
    drain();
    end_test();
  endtask

  task automatic test_in_order_commit();
    arch_idx_t dests [4] = '{3'd1, 3'd4, 3'd1, 3'd7};
    begin_test("in_order_commit");
    for (int i = 0; i < 4; i++) dispatch(dests[i]);
    for (int i = 3; i >= 0; i--) begin
      // reverse order, head last
      cycle(1'b0, '0, 1'b1, phys_tag_t'(ARCH_REGS + i), rob_idx_t'(i), 32'hc0de_0000 + i);
      check_value("early commit", 0, commit_valid);
    end
    for (int i = 0; i < 4; i++) begin
      wait_commit();
      check_value("order dest", dests[i], commit_dest);
      check_value("order tag", ARCH_REGS + i, commit_tag);
      check_value("order value", 32'hc0de_0000 + i, commit_value);
      idle();
    end
    drain();
    end_test();
  endtask

  task automatic test_back_pressure();
    begin_test("back_pressure");
    for (int i = 0; i < ROB_DEPTH; i++) dispatch(arch_idx_t'(i));
    idle();
    check_value("ready when full", 0, dispatch_ready);
    dispatch(3'd3);  // must be dropped
    cycle(1'b0, '0, 1'b1, phys_tag_t'(ARCH_REGS), '0, 32'h0bad_cafe);
    wait_commit();
    check_value("ready after commit", 1, dispatch_ready);
    dispatch(3'd3);
    check_value("slot after wrap", 0, dispatch_rob_idx);
    check_value("recycled tag", 0, dispatch_tag);  // told of dest 0
    drain();
    end_test();
  endtask

  task automatic test_tag_recycling();
    begin_test("tag_recycling");
    for (int i = 0; i < ROB_DEPTH; i++) dispatch(arch_idx_t'(7 - i));
    drain();  // retires free tolds 7 down to 0
    for (int i = 0; i < ROB_DEPTH; i++) begin
      dispatch(arch_idx_t'(i));
      check_value("freed tag order", 7 - i, dispatch_tag);
    end
    drain();
    end_test();
  endtask

  task automatic test_random_traffic();
    int        k;
    logic      dv;
    logic      cv;
    arch_idx_t dd;
    phys_tag_t ct;
    rob_idx_t  ci;
    begin_test("random_traffic");
    for (int n = 0; n < 200; n++) begin
      dv = $urandom % 2;
      dd = $urandom % ARCH_REGS;
      k  = pick_undone(1'b0);
      cv = (k >= 0) && ($urandom % 2);
      ct = cv ? q_tag[k] : '0;
      ci = cv ? q_idx[k] : '0;
      cycle(dv, dd, cv, ct, ci, data_t'($urandom));
    end
    drain();
    // every accepted instruction came back out on the commit port
    check_value("commits vs dispatches", n_dispatched, n_committed);
    end_test();
  endtask

  initial begin
    void'($urandom(32'h830c_80a8));
    reset            = 1'b1;
    dispatch_valid   = 1'b0;
    dispatch_dest    = '0;
    complete_valid   = 1'b0;
    complete_tag     = '0;
    complete_rob_idx = '0;
    complete_value   = '0;
    errors       = 0;
    tests_passed = 0;
    tests_failed = 0;
    n_dispatched = 0;
    n_committed  = 0;
    test_reset_state();
    test_told_chain();
    test_in_order_commit();
    test_back_pressure();
    test_tag_recycling();
    test_random_traffic();
    errors = errors + UUT.rename_core_props.fail_count;
    $display("tests: %0d passed, %0d failed, %0d assertion failures",
             tests_passed, tests_failed, UUT.rename_core_props.fail_count);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
core_pkg.sv
free_list.sv
map_table.sv
reorder_buffer.sv
phys_regfile.sv
retire_stage.sv
rename_core.sv
rename_core_properties.sv
rename_core_tb.sv

// ==== Bender.yml ====
package:
  name: rename_core

sources:
  - core_pkg.sv
  - free_list.sv
  - map_table.sv
  - reorder_buffer.sv
  - phys_regfile.sv
  - retire_stage.sv
  - rename_core.sv
  - target: simulation
    files:
      - rename_core_properties.sv
      - rename_core_tb.sv
